// File: dnc_temporal_link_matrix.f
logic/tlm_arith_pkg.sv
logic/tlm_ctrl_pkg.sv
logic/tlm_mod_adder.sv
logic/tlm_mod_multiplier.sv
logic/tlm_vector_store.sv
logic/tlm_controller.sv
logic/dnc_temporal_link_matrix.sv
dv/tb_dnc_temporal_link_matrix.sv

// File: dv/tb_dnc_temporal_link_matrix.sv
`timescale 1ns/1ps

module tb_dnc_temporal_link_matrix
  import tlm_arith_pkg::*;
  import tlm_ctrl_pkg::*;
();

  // Per-element bound and run budget
  localparam int ELEM_BUDGET = 2 * WORD_W + 12;
  localparam int SUM_NN      = 9 + 25 + 64 + 16 + 1 + 9;
  localparam int RUN_COUNT   = 6;
  localparam int WATCHDOG_CYCLES =
    16 + 40 + 2 * (SUM_NN * (ELEM_BUDGET + 8) + RUN_COUNT * (2 * MAX_N + 12));

  logic  CLK;
  logic  RST;
  logic  START;
  logic  READY;
  word_t SIZE_N_IN;
  word_t MODULO_IN;
  logic  W_IN_ENABLE;
  word_t W_IN;
  logic  P_IN_ENABLE;
  word_t P_IN;
  logic  L_IN_G_ENABLE;
  logic  L_IN_J_ENABLE;
  word_t L_IN;
  logic  L_OUT_G_ENABLE;
  logic  L_OUT_J_ENABLE;
  word_t L_OUT;

  // Stimulus vectors and expected matrix
  word_t w_vec [MAX_N];
  word_t p_vec [MAX_N];
  word_t exp_mat [MAX_N][MAX_N];
  int    exp_n;

  // Output monitor state
  logic started;
  logic after_ready;
  logic prev_j_en;
  int   out_cnt;
  int   ready_cnt;
  int   mon_g;
  int   mon_j;

  // Tallies
  int err_cnt;
  int test_cnt;
  int test_fail_cnt;

  logic [31:0] lfsr_state = 32'hc847fe5c;

  dnc_temporal_link_matrix UUT (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .READY          (READY),
    .SIZE_N_IN      (SIZE_N_IN),
    .MODULO_IN      (MODULO_IN),
    .W_IN_ENABLE    (W_IN_ENABLE),
    .W_IN           (W_IN),
    .P_IN_ENABLE    (P_IN_ENABLE),
    .P_IN           (P_IN),
    .L_IN_G_ENABLE  (L_IN_G_ENABLE),
    .L_IN_J_ENABLE  (L_IN_J_ENABLE),
    .L_IN           (L_IN),
    .L_OUT_G_ENABLE (L_OUT_G_ENABLE),
    .L_OUT_J_ENABLE (L_OUT_J_ENABLE),
    .L_OUT          (L_OUT)
  );

  // 4 ns period
  always #2 CLK = ~CLK;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic value_mismatch(input string msg);
    err_cnt++;
    $display("FAIL t=%0t: %s", $time, msg);
  endtask

  task automatic report_error(input string msg);
    err_cnt++;
    $display("Error at t=%0t: %s", $time, msg);
  endtask

  // Taps 32, 22, 2, 1; one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  // (1 - wg - wj) * lo + wg * pj, all mod m, in wide signed integers
  function automatic word_t link_update(input longint wg, input longint wj,
                                       input longint pj, input longint lo,
                                       input longint m);
    longint coef;
    coef = (1 - wg - wj) % m;
    if (coef < 0) begin
      coef = coef + m;
    end
    return word_t'((coef * lo + wg * pj) % m);
  endfunction

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Row marker only rides on a column strobe
  assert property (@(posedge CLK) disable iff (RST) L_OUT_G_ENABLE |-> L_OUT_J_ENABLE)
    else report_error("L_OUT_G_ENABLE high without L_OUT_J_ENABLE");

  // Strobes last one cycle
  assert property (@(posedge CLK) disable iff (RST) L_OUT_J_ENABLE |=> !L_OUT_J_ENABLE)
    else report_error("L_OUT_J_ENABLE held longer than one cycle");
  assert property (@(posedge CLK) disable iff (RST) READY |=> !READY)
    else report_error("READY held longer than one cycle");

  // Completion never coincides with an output
  assert property (@(posedge CLK) disable iff (RST) READY |-> !L_OUT_J_ENABLE)
    else report_error("READY together with an output strobe");

  always @(posedge CLK) begin
    if (!RST) begin
      if (!started) begin
        assert (!READY && !L_OUT_J_ENABLE && !L_OUT_G_ENABLE && L_OUT == '0)
          else report_error("output activity after reset before any START");
      end
      if (L_OUT_J_ENABLE) begin
        assert (!after_ready)
          else report_error("output strobe after READY without a new START");
        assert (out_cnt < exp_n * exp_n)
          else report_error("more output strobes than N*N");
        if (out_cnt < exp_n * exp_n) begin
          assert (L_OUT == exp_mat[mon_g][mon_j])
            else value_mismatch($sformatf("L_OUT[%0d][%0d] = %0d, expected %0d",
                                          mon_g, mon_j, L_OUT, exp_mat[mon_g][mon_j]));
          assert (L_OUT_G_ENABLE == (mon_j == 0))
            else value_mismatch($sformatf("L_OUT_G_ENABLE = %0b at column %0d",
                                          L_OUT_G_ENABLE, mon_j));
        end
        out_cnt++;
        // Row-major position of the next output
        if (mon_j == exp_n - 1) begin
          mon_j = 0;
          mon_g++;
        end else begin
          mon_j++;
        end
      end
      if (READY) begin
        assert (prev_j_en && out_cnt == exp_n * exp_n)
          else report_error("READY not in the cycle after the last output strobe");
        ready_cnt++;
        after_ready = 1'b1;
      end
      prev_j_en = L_OUT_J_ENABLE;
    end
  end

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////

  // W and P together, then an idle cycle so the held P drains
  task automatic load_vectors(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge CLK);
      #1;
      W_IN_ENABLE = 1'b1;
      W_IN        = w_vec[i];
      P_IN_ENABLE = 1'b1;
      P_IN        = p_vec[i];
      @(posedge CLK);
      #1;
      W_IN_ENABLE = 1'b0;
      P_IN_ENABLE = 1'b0;
    end
  endtask

  task automatic drive_element(input word_t l, input int g, input int j,
                               input word_t m, input bit noisy);
    bit got;
    got = 1'b0;
    @(posedge CLK);
    #1;
    L_IN_J_ENABLE = 1'b1;
    L_IN_G_ENABLE = (j == 0);
    L_IN          = l;
    @(posedge CLK);
    #1;
    L_IN_J_ENABLE = 1'b0;
    L_IN_G_ENABLE = 1'b0;
    L_IN          = '0;
    if (noisy) begin
      // Element, vector and START strobes while busy
      repeat (2) @(posedge CLK);
      #1;
      L_IN_J_ENABLE = 1'b1;
      L_IN          = word_t'(rand_bits(WORD_W) % m);
      W_IN_ENABLE   = 1'b1;
      W_IN          = word_t'(rand_bits(WORD_W) % m);
      P_IN_ENABLE   = 1'b1;
      P_IN          = word_t'(rand_bits(WORD_W) % m);
      START         = 1'b1;
      @(posedge CLK);
      #1;
      L_IN_J_ENABLE = 1'b0;
      W_IN_ENABLE   = 1'b0;
      P_IN_ENABLE   = 1'b0;
      START         = 1'b0;
    end
    for (int k = 0; k < ELEM_BUDGET + 4 && !got; k++) begin
      @(posedge CLK);
      if (L_OUT_J_ENABLE) begin
        got = 1'b1;
      end
    end
    if (!got) begin
      report_error($sformatf("element (%0d,%0d) got no output strobe in time", g, j));
    end
  endtask

  task automatic run_matrix(input string name, input int n, input int m,
                            input bit zero_l, input bit noisy);
    int    errs_before;
    word_t l_mat [MAX_N][MAX_N];
    errs_before = err_cnt;
    for (int i = 0; i < n; i++) begin
      w_vec[i] = word_t'(rand_bits(WORD_W) % m);
      p_vec[i] = word_t'(rand_bits(WORD_W) % m);
    end
    for (int g = 0; g < n; g++) begin
      for (int j = 0; j < n; j++) begin
        l_mat[g][j]   = zero_l ? word_t'(0) : word_t'(rand_bits(WORD_W) % m);
        exp_mat[g][j] = link_update(w_vec[g], w_vec[j], p_vec[j], l_mat[g][j], m);
      end
    end
    @(posedge CLK);
    #1;
    exp_n       = n;
    out_cnt     = 0;
    ready_cnt   = 0;
    mon_g       = 0;
    mon_j       = 0;
    after_ready = 1'b0;
    if (noisy) begin
      // Stray vector strobes in IDLE
      W_IN_ENABLE = 1'b1;
      W_IN        = word_t'(rand_bits(WORD_W) % m);
      P_IN_ENABLE = 1'b1;
      P_IN        = word_t'(rand_bits(WORD_W) % m);
      @(posedge CLK);
      #1;
      W_IN_ENABLE = 1'b0;
      P_IN_ENABLE = 1'b0;
    end
    SIZE_N_IN = word_t'(n);
    MODULO_IN = word_t'(m);
    START     = 1'b1;
    started   = 1'b1;
    @(posedge CLK);
    #1;
    START = 1'b0;
    load_vectors(n);
    for (int g = 0; g < n; g++) begin
      for (int j = 0; j < n; j++) begin
        drive_element(l_mat[g][j], g, j, word_t'(m), noisy);
      end
    end
    // Room for READY and a quiet tail
    repeat (4) @(posedge CLK);
    assert (out_cnt == n * n && ready_cnt == 1)
      else report_error($sformatf("%0d output strobes and %0d READY pulses for N=%0d",
                                  out_cnt, ready_cnt, n));
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      test_fail_cnt++;
      $display("test %s: %0d errors", name, err_cnt - errs_before);
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    CLK           = 1'b0;
    RST           = 1'b1;
    START         = 1'b0;
    SIZE_N_IN     = '0;
    MODULO_IN     = '0;
    W_IN_ENABLE   = 1'b0;
    W_IN          = '0;
    P_IN_ENABLE   = 1'b0;
    P_IN          = '0;
    L_IN_G_ENABLE = 1'b0;
    L_IN_J_ENABLE = 1'b0;
    L_IN          = '0;
    started       = 1'b0;
    after_ready   = 1'b0;
    prev_j_en     = 1'b0;
    out_cnt       = 0;
    ready_cnt     = 0;
    mon_g         = 0;
    mon_j         = 0;
    exp_n         = 0;
    err_cnt       = 0;
    test_cnt      = 0;
    test_fail_cnt = 0;
    repeat (16) @(posedge CLK);
    #1;
    RST = 1'b0;

    // Quiet outputs before the first START
    repeat (20) @(posedge CLK);
    test_cnt++;
    if (err_cnt == 0) begin
      $display("test reset_quiet: ok");
    end else begin
      test_fail_cnt++;
      $display("test reset_quiet: %0d errors", err_cnt);
    end

    run_matrix("rand_n3_m251", 3, 251, 1'b0, 1'b0);
    run_matrix("rand_n5_m40961", 5, 40961, 1'b0, 1'b0);
    run_matrix("rand_n8_m65521", 8, 65521, 1'b0, 1'b0);
    // t = 0, old links all zero
    run_matrix("zero_n4_m40961", 4, 40961, 1'b1, 1'b0);
    run_matrix("zero_n1_m65521", 1, 65521, 1'b1, 1'b0);
    run_matrix("noise_n3_m251", 3, 251, 1'b0, 1'b1);

    $display("%0d tests, %0d failed, %0d errors", test_cnt, test_fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Bound from total elements and loads, doubled
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: logic/dnc_temporal_link_matrix.sv
`timescale 1ns/1ps

module dnc_temporal_link_matrix
  import tlm_arith_pkg::*;
  import tlm_ctrl_pkg::*;
(
  input  logic  CLK,
  input  logic  RST,
  input  logic  START,
  output logic  READY,
  input  word_t SIZE_N_IN,
  input  word_t MODULO_IN,
  input  logic  W_IN_ENABLE,
  input  word_t W_IN,
  input  logic  P_IN_ENABLE,
  input  word_t P_IN,
  // Row marker from the host; position is tracked internally
  input  logic  L_IN_G_ENABLE,
  input  logic  L_IN_J_ENABLE,
  input  word_t L_IN,
  output logic  L_OUT_G_ENABLE,
  output logic  L_OUT_J_ENABLE,
  output word_t L_OUT
);

  // Store access
  vec_wr_t   wr;
  elem_pos_t pos;
  word_t     w_g;
  word_t     w_j;
  word_t     p_j;

  // Shared arithmetic units
  word_t    modulus;
  logic     add_start;
  add_req_t add_req;
  logic     add_ready;
  word_t    add_result;
  logic     mul_start;
  mul_req_t mul_req;
  logic     mul_ready;
  word_t    mul_result;

  //////////////////////////////
  // Sequencer
  //////////////////////////////

  tlm_controller u_ctrl (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .READY          (READY),
    .SIZE_N_IN      (SIZE_N_IN),
    .MODULO_IN      (MODULO_IN),
    .W_IN_ENABLE    (W_IN_ENABLE),
    .P_IN_ENABLE    (P_IN_ENABLE),
    .W_IN           (W_IN),
    .P_IN           (P_IN),
    .L_IN_J_ENABLE  (L_IN_J_ENABLE),
    .L_IN           (L_IN),
    .L_OUT_G_ENABLE (L_OUT_G_ENABLE),
    .L_OUT_J_ENABLE (L_OUT_J_ENABLE),
    .L_OUT          (L_OUT),
    .wr             (wr),
    .pos            (pos),
    .w_g            (w_g),
    .w_j            (w_j),
    .p_j            (p_j),
    .modulus        (modulus),
    .add_start      (add_start),
    .add_req        (add_req),
    .add_ready      (add_ready),
    .add_result     (add_result),
    .mul_start      (mul_start),
    .mul_req        (mul_req),
    .mul_ready      (mul_ready),
    .mul_result     (mul_result)
  );

  //////////////////////////////
  // w and p vectors
  //////////////////////////////

  tlm_vector_store u_store (
    .CLK (CLK),
    .RST (RST),
    .wr  (wr),
    .pos (pos),
    .w_g (w_g),
    .w_j (w_j),
    .p_j (p_j)
  );

  //////////////////////////////
  // Modular units
  //////////////////////////////

  tlm_mod_adder u_adder (
    .CLK     (CLK),
    .RST     (RST),
    .START   (add_start),
    .req     (add_req),
    .modulus (modulus),
    .READY   (add_ready),
    .result  (add_result)
  );

  tlm_mod_multiplier u_mult (
    .CLK     (CLK),
    .RST     (RST),
    .START   (mul_start),
    .req     (mul_req),
    .modulus (modulus),
    .READY   (mul_ready),
    .result  (mul_result)
  );

endmodule

// File: logic/tlm_controller.sv
`timescale 1ns/1ps

module tlm_controller
  import tlm_arith_pkg::*;
  import tlm_ctrl_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  input  logic      START,
  output logic      READY,
  input  word_t     SIZE_N_IN,
  input  word_t     MODULO_IN,
  input  logic      W_IN_ENABLE,
  input  logic      P_IN_ENABLE,
  input  word_t     W_IN,
  input  word_t     P_IN,
  input  logic      L_IN_J_ENABLE,
  input  word_t     L_IN,
  output logic      L_OUT_G_ENABLE,
  output logic      L_OUT_J_ENABLE,
  output word_t     L_OUT,
  output vec_wr_t   wr,
  output elem_pos_t pos,
  input  word_t     w_g,
  input  word_t     w_j,
  input  word_t     p_j,
  output word_t     modulus,
  output logic      add_start,
  output add_req_t  add_req,
  input  logic      add_ready,
  input  word_t     add_result,
  output logic      mul_start,
  output mul_req_t  mul_req,
  input  logic      mul_ready,
  input  word_t     mul_result
);

  ctrl_state_t state;

  // Run length, wide enough to hold MAX_N itself
  logic [IDX_W:0] size_n;
  idx_t           last_idx;

  // Load counters
  logic [IDX_W:0] w_cnt;
  logic [IDX_W:0] p_cnt;
  logic           w_take;
  logic           p_take;

  // P word held back when W wins the store port, en is its valid
  vec_wr_t p_slot;

  // Element operands
  word_t l_reg;
  word_t t1;

  assign last_idx = idx_t'(size_n - 1'b1);

  // W has the port; a P collides only when the slot is full and W arrives too
  assign w_take = W_IN_ENABLE && (w_cnt != size_n);
  assign p_take = P_IN_ENABLE && (p_cnt != size_n) && !(w_take && p_slot.en);

  //////////////////////////////
  // FSM and strobes
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state          <= IDLE;
      size_n         <= '0;
      modulus        <= '0;
      w_cnt          <= '0;
      p_cnt          <= '0;
      p_slot         <= '0;
      wr             <= '0;
      pos            <= '0;
      READY          <= 1'b0;
      L_OUT_G_ENABLE <= 1'b0;
      L_OUT_J_ENABLE <= 1'b0;
      L_OUT          <= '0;
      add_start      <= 1'b0;
      mul_start      <= 1'b0;
    end else begin
      // Single-cycle strobes by default
      wr.en          <= 1'b0;
      READY          <= 1'b0;
      L_OUT_G_ENABLE <= 1'b0;
      L_OUT_J_ENABLE <= 1'b0;
      add_start      <= 1'b0;
      mul_start      <= 1'b0;
      case (state)
        IDLE: begin
          if (START) begin
            size_n  <= SIZE_N_IN[IDX_W:0];
            modulus <= MODULO_IN;
            w_cnt   <= '0;
            p_cnt   <= '0;
            p_slot  <= '0;
            pos     <= '0;
            state   <= LOAD;
          end
        end
        LOAD: begin
          if (w_take) begin
            wr    <= '{en: 1'b1, sel: SEL_W, idx: idx_t'(w_cnt), data: W_IN};
            w_cnt <= w_cnt + 1'b1;
            if (p_take) begin
              p_slot <= '{en: 1'b1, sel: SEL_P, idx: idx_t'(p_cnt), data: P_IN};
              p_cnt  <= p_cnt + 1'b1;
            end
          end else if (p_slot.en) begin
            // Drain the held word, refill with a fresh P
            wr <= p_slot;
            if (p_take) begin
              p_slot <= '{en: 1'b1, sel: SEL_P, idx: idx_t'(p_cnt), data: P_IN};
              p_cnt  <= p_cnt + 1'b1;
            end else begin
              p_slot.en <= 1'b0;
            end
          end else if (p_take) begin
            wr    <= '{en: 1'b1, sel: SEL_P, idx: idx_t'(p_cnt), data: P_IN};
            p_cnt <= p_cnt + 1'b1;
          end
          // A held P drains on this same edge
          if (w_cnt == size_n && p_cnt == size_n) begin
            state <= WAIT_ELEM;
          end
        end
        WAIT_ELEM: begin
          if (L_IN_J_ENABLE) begin
            add_start <= 1'b1;
            state     <= SUM_W;
          end
        end
        SUM_W: begin
          if (add_ready) begin
            add_start <= 1'b1;
            state     <= COEF;
          end
        end
        COEF: begin
          if (add_ready) begin
            mul_start <= 1'b1;
            state     <= MUL_L;
          end
        end
        MUL_L: begin
          if (mul_ready) begin
            mul_start <= 1'b1;
            state     <= MUL_WP;
          end
        end
        MUL_WP: begin
          if (mul_ready) begin
            add_start <= 1'b1;
            state     <= ACCUM;
          end
        end
        ACCUM: begin
          if (add_ready) begin
            L_OUT          <= add_result;
            L_OUT_J_ENABLE <= 1'b1;
            L_OUT_G_ENABLE <= (pos.j == '0);
            // Row-major walk
            if (pos.j == last_idx) begin
              pos.j <= '0;
              pos.g <= pos.g + 1'b1;
            end else begin
              pos.j <= pos.j + 1'b1;
            end
            if (pos.g == last_idx && pos.j == last_idx) begin
              state <= DONE;
            end else begin
              state <= WAIT_ELEM;
            end
          end
        end
        DONE: begin
          READY <= 1'b1;
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  //////////////////////////////
  // Operand datapath
  //////////////////////////////

  // Requests sit beside their start strobes
  always_ff @(posedge CLK) begin
    case (state)
      WAIT_ELEM: begin
        l_reg   <= L_IN;
        // s = w[g] + w[j]
        add_req <= '{op: ADD_OP, a: w_g, b: w_j};
      end
      SUM_W: begin
        // c = 1 - s, M >= 2 keeps 1 a residue
        add_req <= '{op: SUB_OP, a: word_t'(1), b: add_result};
      end
      COEF: begin
        // t1 = c * L
        mul_req <= '{a: add_result, b: l_reg};
      end
      MUL_L: begin
        t1      <= mul_result;
        // t2 = w[g] * p[j]
        mul_req <= '{a: w_g, b: p_j};
      end
      MUL_WP: begin
        add_req <= '{op: ADD_OP, a: t1, b: mul_result};
      end
      default: begin
      end
    endcase
  end

endmodule

// File: logic/tlm_vector_store.sv
`timescale 1ns/1ps

module tlm_vector_store
  import tlm_arith_pkg::*;
  import tlm_ctrl_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  input  vec_wr_t   wr,
  input  elem_pos_t pos,
  output word_t     w_g,
  output word_t     w_j,
  output word_t     p_j
);

  // Write weighting and precedence weighting
  word_t w_mem [MAX_N];
  word_t p_mem [MAX_N];

  //////////////////////////////
  // Write port
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < MAX_N; i++) begin
        w_mem[i] <= '0;
        p_mem[i] <= '0;
      end
    end else if (wr.en) begin
      // One vector per write
      if (wr.sel == SEL_W) begin
        w_mem[wr.idx] <= wr.data;
      end else begin
        p_mem[wr.idx] <= wr.data;
      end
    end
  end

  //////////////////////////////
  // Read ports
  //////////////////////////////

  // Row weight w[g]
  assign w_g = w_mem[pos.g];

  // Column weight w[j] and precedence p[j]
  assign w_j = w_mem[pos.j];
  assign p_j = p_mem[pos.j];

endmodule

// File: logic/tlm_mod_multiplier.sv
`timescale 1ns/1ps

module tlm_mod_multiplier import tlm_arith_pkg::*; (
  input  logic     CLK,
  input  logic     RST,
  input  logic     START,
  input  mul_req_t req,
  input  word_t    modulus,
  output logic     READY,
  output word_t    result
);

  // Control state
  logic             busy;
  logic [CNT_W-1:0] bit_cnt;

  // Operands and running product
  word_t a_reg;
  word_t b_reg;
  word_t acc;

  // One interleaved step
  logic [WORD_W:0] dbl_raw;
  word_t           dbl_mod;
  logic [WORD_W:0] add_raw;
  word_t           add_mod;
  word_t           acc_next;

  // Value below 2M back into 0 .. M-1
  function automatic word_t fold(input logic [WORD_W:0] x, input word_t m);
    logic [WORD_W:0] m_ext;
    m_ext = {1'b0, m};
    if (x >= m_ext) begin
      return word_t'(x - m_ext);
    end
    return word_t'(x);
  endfunction

  //////////////////////////////
  // Step datapath
  //////////////////////////////

  always_comb begin
    // acc = 2*acc mod M
    dbl_raw = {acc, 1'b0};
    dbl_mod = fold(dbl_raw, modulus);
    // Then + a mod M when the b bit is set
    add_raw = {1'b0, dbl_mod} + {1'b0, a_reg};
    add_mod = fold(add_raw, modulus);
    // b scanned MSB first
    acc_next = b_reg[bit_cnt] ? add_mod : dbl_mod;
  end

  //////////////////////////////
  // Sequencing
  //////////////////////////////

  // WORD_W steps after capture, ready on the last one
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy    <= 1'b0;
      bit_cnt <= '0;
      READY   <= 1'b0;
    end else begin
      READY <= 1'b0;
      if (busy) begin
        if (bit_cnt == '0) begin
          busy  <= 1'b0;
          READY <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt - 1'b1;
        end
      end else if (START) begin
        busy    <= 1'b1;
        bit_cnt <= CNT_W'(WORD_W - 1);
      end
    end
  end

  // Operands, accumulator and result
  always_ff @(posedge CLK) begin
    if (busy) begin
      acc <= acc_next;
      if (bit_cnt == '0) begin
        result <= acc_next;
      end
    end else if (START) begin
      a_reg <= req.a;
      b_reg <= req.b;
      acc   <= '0;
    end
  end

endmodule

// File: logic/tlm_mod_adder.sv
`timescale 1ns/1ps

module tlm_mod_adder import tlm_arith_pkg::*; (
  input  logic     CLK,
  input  logic     RST,
  input  logic     START,
  input  add_req_t req,
  input  word_t    modulus,
  output logic     READY,
  output word_t    result
);

  // One guard bit above the word for carry and borrow
  logic [WORD_W:0] sum_raw;
  logic [WORD_W:0] diff_raw;
  logic [WORD_W:0] mod_ext;
  word_t           next_result;

  //////////////////////////////
  // Combinational correction
  //////////////////////////////

  always_comb begin
    mod_ext  = {1'b0, modulus};
    sum_raw  = {1'b0, req.a} + {1'b0, req.b};
    diff_raw = {1'b0, req.a} - {1'b0, req.b};
    if (req.op == ADD_OP) begin
      // Sum of two residues is below 2M, one subtraction folds it
      if (sum_raw >= mod_ext) begin
        next_result = word_t'(sum_raw - mod_ext);
      end else begin
        next_result = word_t'(sum_raw);
      end
    end else begin
      // Borrow out of the top bit means a < b
      if (diff_raw[WORD_W]) begin
        next_result = word_t'(diff_raw + mod_ext);
      end else begin
        next_result = word_t'(diff_raw);
      end
    end
  end

  //////////////////////////////
  // Strobe and result
  //////////////////////////////

  // Ready follows start by exactly one cycle
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      READY <= 1'b0;
    end else begin
      READY <= START;
    end
  end

  always_ff @(posedge CLK) begin
    if (START) begin
      result <= next_result;
    end
  end

endmodule

// File: logic/tlm_ctrl_pkg.sv
package tlm_ctrl_pkg;

  import tlm_arith_pkg::*;

  //////////////////////////////
  // Vector geometry
  //////////////////////////////

  // Longest w and p vectors
  localparam int MAX_N = 8;

  // Index covers 0 .. MAX_N-1
  localparam int IDX_W = 3;

  typedef logic [IDX_W-1:0] idx_t;

  //////////////////////////////
  // Store access
  //////////////////////////////

  // Which vector a write targets
  typedef enum logic {
    SEL_W,
    SEL_P
  } vec_sel_t;

  // One store write
  typedef struct packed {
    logic     en;
    vec_sel_t sel;
    idx_t     idx;
    word_t    data;
  } vec_wr_t;

  // Current matrix element, row g and column j
  typedef struct packed {
    idx_t g;
    idx_t j;
  } elem_pos_t;

  //////////////////////////////
  // Controller FSM
  //////////////////////////////

  typedef enum logic [3:0] {
    IDLE,
    LOAD,
    WAIT_ELEM,
    SUM_W,
    COEF,
    MUL_L,
    MUL_WP,
    ACCUM,
    DONE
  } ctrl_state_t;

endpackage

// File: logic/tlm_arith_pkg.sv
package tlm_arith_pkg;

  //////////////////////////////
  // Word geometry
  //////////////////////////////

  // Data words and modulus share one width
  localparam int WORD_W = 16;

  // Bit counter width for the iterative multiplier
  localparam int CNT_W = $clog2(WORD_W);

  typedef logic [WORD_W-1:0] word_t;

  //////////////////////////////
  // Adder request
  //////////////////////////////

  // Adder function select
  typedef enum logic {
    ADD_OP,
    SUB_OP
  } add_op_t;

  // One adder request, a op b
  typedef struct packed {
    add_op_t op;
    word_t   a;
    word_t   b;
  } add_req_t;

  //////////////////////////////
  // Multiplier request
  //////////////////////////////

  // One multiplier request, a times b
  typedef struct packed {
    word_t a;
    word_t b;
  } mul_req_t;

endpackage
